// File: build.f
hw/xvid_pkg.sv
hw/bus_interface.sv
hw/reg_control.sv
hw/vram_port.sv
hw/xvid_regs_top.sv
verification/tb_xvid_regs.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_xvid_regs -f build.f -o sim_xvid_regs

run: compile
	./obj_dir/sim_xvid_regs | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_xvid_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xvid_regs;
    import xvid_pkg::*;

    localparam int VRAM_AW      = 10;
    localparam int PIPE_CREDITS = 2;
    localparam int VRAM_WORDS   = 2**VRAM_AW;
    localparam int N_BURST      = 16;
    localparam int N_SWEEP      = 64;
    // bus selects of fill, readback, odd-only, unused, burst and sweep
    localparam int N_SELECTS  = (2 + 2*VRAM_WORDS) + 12 + 6 + 24 + (10 + 4*N_BURST) + 4*N_SWEEP;
    localparam int TIMEOUT_NS = N_SELECTS * 16 * 20 + 20000;   // 16 cycles per select

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   bus_cs_n;
    logic                   bus_rd_nwr;
    logic                   bus_bytesel;
    logic [REG_NUM_W-1:0]   bus_reg_num;
    logic [7:0]             bus_wdata;
    logic [7:0]             bus_rdata;

    // reference model state
    logic [VRAM_AW-1:0]     m_wr_addr;
    logic [VRAM_AW-1:0]     m_rd_addr;
    logic [WORD_W-1:0]      m_incr;
    logic [WORD_W-1:0]      m_rd_word;              // prefetched word
    logic [WORD_W-1:0]      m_vram [VRAM_WORDS];
    logic [REG_NUM_W-1:0]   m_even_reg;             // last even byte and its register
    logic [7:0]             m_even_data;
    logic [31:0]            rng_state;

    xvid_regs_top #(.VRAM_AW(VRAM_AW), .PIPE_CREDITS(PIPE_CREDITS)) xvid_regs_top_i (
        .clk(clk), .reset_i(reset_i), .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr),
        .bus_bytesel_i(bus_bytesel), .bus_reg_num_i(bus_reg_num), .bus_data_i(bus_wdata),
        .bus_data_o(bus_rdata)
    );

    always #10 clk = ~clk;                          // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // upper half of the next xorshift value
    function automatic logic [WORD_W-1:0] random_word();
        logic [31:0] x;
        x = next_random();
        return x[31:16];
    endfunction

    // odd multiplier makes every address bit matter
    function automatic logic [WORD_W-1:0] fill_word(input int unsigned a);
        logic [31:0] p;
        p = a * 32'h0000_9e37;
        return p[15:0] ^ 16'h5ac3;
    endfunction

    function automatic logic [WORD_W-1:0] model_word(input logic [REG_NUM_W-1:0] r);
        case (r)
            REG_VRAM_DATA: return m_rd_word;
            REG_WR_ADDR:   return {{(WORD_W - VRAM_AW){1'b0}}, m_wr_addr};
            REG_RD_ADDR:   return {{(WORD_W - VRAM_AW){1'b0}}, m_rd_addr};
            REG_INCR:      return m_incr;
            default:       return '0;               // 4 to 15 read as zero
        endcase
    endfunction

    // one select of 8 cycles then 8 idle with inputs changing 2 ns after the edge
    task automatic bus_select(input logic rnw, input logic [REG_NUM_W-1:0] r, input logic odd,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        #2;
        bus_cs_n    = CS_ENABLED;
        bus_rd_nwr  = rnw;
        bus_bytesel = odd;
        bus_reg_num = r;
        bus_wdata   = wdata;
        repeat (8) @(posedge clk);
        #2;
        rdata    = bus_rdata;                       // held stable for the whole select
        bus_cs_n = ~CS_ENABLED;
        repeat (7) @(posedge clk);
    endtask

    task automatic bus_write(input logic [REG_NUM_W-1:0] r, input logic [7:0] b,
                             input logic odd);
        logic [7:0] unused;
        logic [WORD_W-1:0] w;
        bus_select(~RNW_READ, r, odd, b, unused);
        if (!odd) begin
            m_even_reg  = r;                        // even byte only waits
            m_even_data = b;
        end else begin
            w = (r == m_even_reg) ? {m_even_data, b} : {8'h00, b};
            case (r)
                REG_VRAM_DATA: begin
                    m_vram[m_wr_addr] = w;
                    m_wr_addr = m_wr_addr + m_incr[VRAM_AW-1:0];   // wraps at vram size
                end
                REG_WR_ADDR: m_wr_addr = w[VRAM_AW-1:0];
                REG_RD_ADDR: begin
                    m_rd_addr = w[VRAM_AW-1:0];
                    m_rd_word = m_vram[m_rd_addr];  // prefetch at new address
                end
                REG_INCR: m_incr = w;
                default: ;
            endcase
        end
    endtask

    task automatic bus_read(input logic [REG_NUM_W-1:0] r, input logic odd,
                            output logic [7:0] result);
        bus_select(RNW_READ, r, odd, 8'h00, result);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_read(input string name, input logic [REG_NUM_W-1:0] r,
                              input logic odd);
        logic [WORD_W-1:0] w;
        logic [7:0] act;
        w = model_word(r);
        bus_read(r, odd, act);
        check_byte(name, odd ? w[7:0] : w[15:8], act);
        if (odd && (r == REG_VRAM_DATA)) begin      // consumed word makes way for the next
            m_rd_addr = m_rd_addr + m_incr[VRAM_AW-1:0];
            m_rd_word = m_vram[m_rd_addr];
        end
    endtask

    task automatic write_word(input logic [REG_NUM_W-1:0] r, input logic [WORD_W-1:0] w);
        bus_write(r, w[15:8], 1'b0);
        bus_write(r, w[7:0], 1'b1);
    endtask

    task automatic read_word(input string name, input logic [REG_NUM_W-1:0] r);
        check_read(name, r, 1'b0);
        check_read(name, r, 1'b1);
    endtask

    task automatic run_sweep();
        logic [31:0] r;
        logic [WORD_W-1:0] w;
        for (int i = 0; i < N_SWEEP; i++) begin
            r = next_random();
            w = random_word();
            case (r % 6)
                0: begin
                    write_word(REG_WR_ADDR, w);
                    read_word("sweep wr_addr", REG_WR_ADDR);
                end
                1: write_word(REG_INCR, w);
                2: write_word(REG_VRAM_DATA, w);
                3: read_word("sweep data read", REG_VRAM_DATA);
                4: write_word(REG_RD_ADDR, w);
                default: begin
                    write_word(REG_VRAM_DATA, w);   // write then read keeps queue order
                    read_word("sweep write then read", REG_VRAM_DATA);
                end
            endcase
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the bus traffic did not complete in the expected time");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        logic [VRAM_AW-1:0] start;
        reset_i     = 1'b1;
        bus_cs_n    = ~CS_ENABLED;
        bus_rd_nwr  = RNW_READ;
        bus_bytesel = 1'b0;
        bus_reg_num = '0;
        bus_wdata   = 8'h00;
        rng_state   = 32'hfe0b;
        m_wr_addr   = '0;
        m_rd_addr   = '0;
        m_incr      = 16'h0001;                     // reset increment
        m_rd_word   = '0;
        m_even_reg  = '0;
        m_even_data = 8'h00;
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // fill whole vram so every prefetch reads known data
        write_word(REG_WR_ADDR, 16'h0000);
        for (int a = 0; a < VRAM_WORDS; a++) begin
            write_word(REG_VRAM_DATA, fill_word(a));
        end

        // register readback with masked addresses
        write_word(REG_WR_ADDR, random_word());
        read_word("readback wr_addr", REG_WR_ADDR);
        write_word(REG_RD_ADDR, random_word());
        read_word("readback rd_addr", REG_RD_ADDR);
        write_word(REG_INCR, random_word());
        read_word("readback incr", REG_INCR);

        // even byte to one register and odd byte to another
        r = next_random();
        bus_write(REG_WR_ADDR, r[15:8], 1'b0);
        bus_write(REG_INCR, r[7:0], 1'b1);
        read_word("odd-only incr", REG_INCR);
        read_word("odd-only wr_addr untouched", REG_WR_ADDR);

        for (int n = 4; n < 16; n++) begin
            read_word("unused register", REG_NUM_W'(n));
        end

        // auto-increment burst and readback
        r     = next_random();
        start = r[VRAM_AW-1:0];
        write_word(REG_INCR, WORD_W'(r[18:16]) + 16'd1);
        write_word(REG_WR_ADDR, WORD_W'(start));
        for (int k = 0; k < N_BURST; k++) begin
            write_word(REG_VRAM_DATA, random_word());
        end
        read_word("burst end wr_addr", REG_WR_ADDR);    // stride of the write address
        write_word(REG_RD_ADDR, WORD_W'(start));
        for (int k = 0; k < N_BURST; k++) begin
            read_word("burst readback", REG_VRAM_DATA);
        end
        read_word("burst end rd_addr", REG_RD_ADDR);

        run_sweep();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/xvid_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module xvid_regs_top #(
    parameter int VRAM_AW      = 10,                // vram word address width
    parameter int PIPE_CREDITS = 2                  // request queue depth
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          bus_cs_n_i,
    input  logic                          bus_rd_nwr_i,
    input  logic                          bus_bytesel_i,
    input  logic [xvid_pkg::REG_NUM_W-1:0] bus_reg_num_i,
    input  logic [7:0]                    bus_data_i,
    output logic [7:0]                    bus_data_o
);
    import xvid_pkg::*;

    // bus capture to register control
    logic                   write_strobe;
    logic                   read_strobe;
    logic                   read_odd;
    logic [REG_NUM_W-1:0]   reg_num;
    logic [WORD_W-1:0]      wr_word;
    logic [WORD_W-1:0]      rd_word;

    // register control to vram port
    logic                   req_valid;
    logic                   req_write;
    logic [VRAM_AW-1:0]     req_addr;
    logic [WORD_W-1:0]      req_data;
    logic                   credit;
    logic                   rd_valid;
    logic [WORD_W-1:0]      rd_data;

    bus_interface bus_interface_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .read_odd_o     (read_odd),
        .reg_num_o      (reg_num),
        .reg_data_o     (wr_word),
        .reg_data_i     (rd_word)
    );

    reg_control #(
        .VRAM_AW        (VRAM_AW),
        .PIPE_CREDITS   (PIPE_CREDITS)
    ) reg_control_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .read_odd_i     (read_odd),
        .reg_num_i      (reg_num),
        .reg_data_i     (wr_word),
        .reg_data_o     (rd_word),
        .req_valid_o    (req_valid),
        .req_write_o    (req_write),
        .req_addr_o     (req_addr),
        .req_data_o     (req_data),
        .credit_i       (credit),
        .rd_valid_i     (rd_valid),
        .rd_data_i      (rd_data)
    );

    vram_port #(
        .VRAM_AW        (VRAM_AW),
        .PIPE_CREDITS   (PIPE_CREDITS)
    ) vram_port_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid),
        .req_write_i    (req_write),
        .req_addr_i     (req_addr),
        .req_data_i     (req_data),
        .credit_o       (credit),
        .rd_valid_o     (rd_valid),
        .rd_data_o      (rd_data)
    );

endmodule

`default_nettype wire

// File: hw/vram_port.sv
`timescale 1ns/1ps
`default_nettype none

module vram_port #(
    parameter int VRAM_AW      = 10,                    // vram word address width
    parameter int PIPE_CREDITS = 2                      // queue depth
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        req_valid_i,
    input  logic                        req_write_i,    // 1 write, 0 read
    input  logic [VRAM_AW-1:0]          req_addr_i,
    input  logic [xvid_pkg::WORD_W-1:0] req_data_i,
    output logic                        credit_o,       // pulses on each pop
    output logic                        rd_valid_o,
    output logic [xvid_pkg::WORD_W-1:0] rd_data_o
);
    import xvid_pkg::*;

    localparam int PTR_W = (PIPE_CREDITS > 1) ? $clog2(PIPE_CREDITS) : 1;
    localparam int CNT_W = $clog2(PIPE_CREDITS + 1);

    // request queue, never overfilled since the sender holds credits
    logic                   q_write [PIPE_CREDITS];
    logic [VRAM_AW-1:0]     q_addr  [PIPE_CREDITS];
    logic [WORD_W-1:0]      q_data  [PIPE_CREDITS];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   pop;

    // single-port video memory
    logic [WORD_W-1:0]      mem [2**VRAM_AW];

    // pointer wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        if (p == PTR_W'(PIPE_CREDITS - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign pop      = (count != '0);                // one entry per cycle
    assign credit_o = pop;

    // queue pointers and read response valid
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            count      <= count + CNT_W'(req_valid_i) - CNT_W'(pop);
            rd_valid_o <= pop && !q_write[rd_ptr];  // reads answer one cycle after pop
            if (req_valid_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            q_write[wr_ptr] <= req_write_i;
            q_addr[wr_ptr]  <= req_addr_i;
            q_data[wr_ptr]  <= req_data_i;
        end
    end

    // apply head entry to memory
    always_ff @(posedge clk) begin
        if (pop) begin
            if (q_write[rd_ptr]) begin
                mem[q_addr[rd_ptr]] <= q_data[rd_ptr];
            end
            rd_data_o <= mem[q_addr[rd_ptr]];       // registered read, only used on reads
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_control.sv
`timescale 1ns/1ps
`default_nettype none

module reg_control #(
    parameter int VRAM_AW      = 10,                      // vram word address width
    parameter int PIPE_CREDITS = 2                        // queue depth downstream
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          write_strobe_i,
    input  logic                          read_strobe_i,
    input  logic                          read_odd_i,
    input  logic [xvid_pkg::REG_NUM_W-1:0] reg_num_i,
    input  logic [xvid_pkg::WORD_W-1:0]   reg_data_i,     // word to write
    output logic [xvid_pkg::WORD_W-1:0]   reg_data_o,     // word of the selected register
    output logic                          req_valid_o,
    output logic                          req_write_o,    // 1 write, 0 read
    output logic [VRAM_AW-1:0]            req_addr_o,
    output logic [xvid_pkg::WORD_W-1:0]   req_data_o,
    input  logic                          credit_i,       // one queue entry freed
    input  logic                          rd_valid_i,
    input  logic [xvid_pkg::WORD_W-1:0]   rd_data_i
);
    import xvid_pkg::*;

    localparam int CNT_W = $clog2(PIPE_CREDITS + 1);

    // register file
    logic [VRAM_AW-1:0]     wr_addr;
    logic [VRAM_AW-1:0]     rd_addr;
    logic [WORD_W-1:0]      incr;
    logic [WORD_W-1:0]      rd_word;            // prefetched vram word

    logic [VRAM_AW-1:0]     incr_a;             // increment wraps at vram size
    logic [VRAM_AW-1:0]     rd_next;
    logic                   data_read;          // odd byte read of the data window

    // request from this cycle's strobe
    logic                   new_req;
    logic                   new_write;
    logic [VRAM_AW-1:0]     new_addr;
    logic [WORD_W-1:0]      new_data;

    // credit counter and one-entry holding register
    logic [CNT_W-1:0]       credits;
    logic                   has_credit;
    logic                   hold_valid;
    logic                   hold_write;
    logic [VRAM_AW-1:0]     hold_addr;
    logic [WORD_W-1:0]      hold_data;
    logic                   send_hold;
    logic                   send_new;
    logic                   park_new;

    assign incr_a    = incr[VRAM_AW-1:0];
    assign rd_next   = rd_addr + incr_a;
    assign data_read = read_strobe_i && read_odd_i && (reg_num_i == REG_VRAM_DATA);

    // decode strobes into vram requests
    always_comb begin
        new_req   = 1'b0;
        new_write = 1'b0;
        new_addr  = wr_addr;
        new_data  = reg_data_i;
        if (write_strobe_i && (reg_num_i == REG_VRAM_DATA)) begin
            new_req   = 1'b1;                   // store at the write address
            new_write = 1'b1;
        end else if (write_strobe_i && (reg_num_i == REG_RD_ADDR)) begin
            new_req  = 1'b1;                    // prefetch at the new read address
            new_addr = reg_data_i[VRAM_AW-1:0];
        end else if (data_read) begin
            new_req  = 1'b1;                    // word consumed, fetch the next one
            new_addr = rd_next;
        end
    end

    assign has_credit = (credits != '0);
    assign send_hold  = hold_valid && has_credit;               // parked request goes first
    assign send_new   = new_req && has_credit && !hold_valid;
    assign park_new   = new_req && !send_new;                   // no credit, or hold busy

    // register updates, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_addr <= '0;
            rd_addr <= '0;
            incr    <= WORD_W'(1);
            rd_word <= '0;
        end else begin
            if (write_strobe_i) begin
                case (reg_num_i)
                    REG_VRAM_DATA: wr_addr <= wr_addr + incr_a;   // auto-increment
                    REG_WR_ADDR:   wr_addr <= reg_data_i[VRAM_AW-1:0];
                    REG_RD_ADDR:   rd_addr <= reg_data_i[VRAM_AW-1:0];
                    REG_INCR:      incr    <= reg_data_i;
                    default: ;                                  // unused registers
                endcase
            end
            if (data_read) begin
                rd_addr <= rd_next;
            end
            if (rd_valid_i) begin
                rd_word <= rd_data_i;           // prefetch result
            end
        end
    end

    // credit counter and request valid
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credits     <= CNT_W'(PIPE_CREDITS);
            hold_valid  <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            credits     <= credits - CNT_W'(send_hold || send_new) + CNT_W'(credit_i);
            req_valid_o <= send_hold || send_new;
            if (park_new) begin
                hold_valid <= 1'b1;
            end else if (send_hold) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // request payload, from hold or straight from the strobe
    always_ff @(posedge clk) begin
        if (park_new) begin
            hold_write <= new_write;
            hold_addr  <= new_addr;
            hold_data  <= new_data;
        end
        if (send_hold) begin
            req_write_o <= hold_write;
            req_addr_o  <= hold_addr;
            req_data_o  <= hold_data;
        end else if (send_new) begin
            req_write_o <= new_write;
            req_addr_o  <= new_addr;
            req_data_o  <= new_data;
        end
    end

    // readback mux, addresses zero extended
    always_comb begin
        case (reg_num_i)
            REG_VRAM_DATA: reg_data_o = rd_word;
            REG_WR_ADDR:   reg_data_o = {{(WORD_W - VRAM_AW){1'b0}}, wr_addr};
            REG_RD_ADDR:   reg_data_o = {{(WORD_W - VRAM_AW){1'b0}}, rd_addr};
            REG_INCR:      reg_data_o = incr;
            default:       reg_data_o = '0; // registers 4 to 15
        endcase
    end

endmodule

`default_nettype wire

// File: hw/bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module bus_interface (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         bus_cs_n_i,      // chip select, async
    input  logic                         bus_rd_nwr_i,    // read / not write, async
    input  logic                         bus_bytesel_i,   // 0 even byte, 1 odd byte
    input  logic [xvid_pkg::REG_NUM_W-1:0] bus_reg_num_i, // register number, async
    input  logic [7:0]                   bus_data_i,      // write byte from host
    output logic [7:0]                   bus_data_o,      // read byte to host
    output logic                         write_strobe_o,  // one cycle, odd byte write
    output logic                         read_strobe_o,   // one cycle, any read
    output logic                         read_odd_o,      // read was of the odd byte
    output logic [xvid_pkg::REG_NUM_W-1:0] reg_num_o,     // synchronized register number
    output logic [xvid_pkg::WORD_W-1:0]  reg_data_o,      // assembled write word
    input  logic [xvid_pkg::WORD_W-1:0]  reg_data_i       // readback word
);
    import xvid_pkg::*;

    // two-stage synchronizers, new sample enters at the top and shifts down
    logic [2:0]                 sel_r;          // extra low bit keeps the previous level
    logic [1:0]                 read_r;
    logic [1:0]                 bytesel_r;
    logic [1:0][REG_NUM_W-1:0]  reg_num_r;
    logic [1:0][7:0]            data_r;

    // synchronized views of the bus
    logic                       sel_rise;       // select just became active
    logic                       sel_held;       // select active past its rising edge
    logic                       is_write;
    logic                       bytesel;
    logic [REG_NUM_W-1:0]       reg_num;
    logic [7:0]                 data;

    // even byte waits here for its odd partner
    logic [REG_NUM_W-1:0]       even_reg;
    logic [7:0]                 even_data;

    assign sel_rise = (sel_r[1:0] == 2'b10);    // synced high, previous low
    assign sel_held = sel_r[0];
    assign is_write = ~read_r[0];
    assign bytesel  = bytesel_r[0];
    assign reg_num  = reg_num_r[0];
    assign data     = data_r[0];

    assign reg_num_o = reg_num;                 // reg_control selects readback with this

    // synchronizer shift chains
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_r <= 3'b000;                    // no select seen
        end else begin
            sel_r <= {(bus_cs_n_i == CS_ENABLED), sel_r[2:1]};   // stored active high
        end
    end

    always_ff @(posedge clk) begin
        read_r    <= {(bus_rd_nwr_i == RNW_READ), read_r[1]};
        bytesel_r <= {bus_bytesel_i, bytesel_r[1]};
        reg_num_r <= {bus_reg_num_i, reg_num_r[1]};
        data_r    <= {bus_data_i, data_r[1]};
    end

    // strobes and even byte buffer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            read_odd_o     <= 1'b0;
            even_reg       <= '0;
            even_data      <= 8'h00;
        end else begin
            write_strobe_o <= 1'b0;             // pulses last one cycle
            read_strobe_o  <= 1'b0;
            if (sel_rise) begin
                if (is_write) begin
                    if (bytesel) begin
                        write_strobe_o <= 1'b1; // odd byte completes the word
                    end else begin
                        even_reg  <= reg_num;   // remember which register it was for
                        even_data <= data;
                    end
                end else begin
                    read_strobe_o <= 1'b1;
                    read_odd_o    <= bytesel;
                end
            end
        end
    end

    // assembled word, upper byte only if the even byte went to the same register
    always_ff @(posedge clk) begin
        if (sel_rise && is_write && bytesel) begin
            if (reg_num == even_reg) begin
                reg_data_o <= {even_data, data};
            end else begin
                reg_data_o <= {8'h00, data};    // odd-only write
            end
        end
    end

    // read byte tracks register and bytesel until the select is taken,
    // then holds so a prefetch during the select cannot change it
    always_ff @(posedge clk) begin
        if (!sel_held) begin
            bus_data_o <= bytesel ? reg_data_i[7:0] : reg_data_i[15:8];
        end
    end

endmodule

`default_nettype wire

// File: hw/xvid_pkg.sv
`default_nettype none

package xvid_pkg;

    // host bus levels
    localparam logic CS_ENABLED = 1'b0;              // bus_cs_n_i level that selects the chip
    localparam logic RNW_READ   = 1'b1;              // bus_rd_nwr_i level for a read

    // word widths
    localparam int REG_NUM_W = 4;                    // register number width
    localparam int WORD_W    = 16;                   // register and vram word width

    // register numbers, 4 to 15 unused and read as zero
    localparam logic [REG_NUM_W-1:0] REG_VRAM_DATA = 4'h0;  // vram data window
    localparam logic [REG_NUM_W-1:0] REG_WR_ADDR   = 4'h1;  // vram write address
    localparam logic [REG_NUM_W-1:0] REG_RD_ADDR   = 4'h2;  // vram read address
    localparam logic [REG_NUM_W-1:0] REG_INCR      = 4'h3;  // auto-increment amount

endpackage

`default_nettype wire
